//--- vlog.f
+incdir+include
hw/board_pkg.sv
hw/move_pkg.sv
hw/lane_if.sv
hw/board_decoder.sv
hw/attack_unit.sv
hw/piece_lane.sv
hw/move_arbiter.sv
hw/move_generator.sv
testbench/tb_move_generator.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f \
    --top-module tb_move_generator \
    -o sim_move_generator

./obj_dir/sim_move_generator 2>&1 | tee sim.log

if grep -q "Test failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi

echo "simulation finished without failures"

//--- testbench/tb_move_generator.sv
`timescale 1ns/10ps
`include "movegen_params.svh"

module tb_move_generator import board_pkg::*, move_pkg::*; ();

    localparam int CLK_PERIOD = 40;
    localparam int RESET_CYCLES = 10;
    localparam int DIRECTED_BOARDS = 10;
    localparam int RANDOM_BOARDS = 200;
    localparam int CYCLES_PER_BOARD = 200;
    localparam int KNIGHT_DR [8] = '{2, 2, 1, 1, -1, -1, -2, -2};
    localparam int KNIGHT_DF [8] = '{1, -1, 2, -2, 2, -2, 1, -1};

    logic clk_in;
    logic rst_in;
    logic valid_in;
    logic black_to_move;
    bitboard_t white_pieces;
    bitboard_t knights;
    bitboard_t bishops;
    bitboard_t rooks;
    bitboard_t queens;
    square_t white_king;
    square_t black_king;
    move_t move;
    logic move_valid;
    logic ready;

    integer seed;
    int errors;
    int test_errors;
    int tests_run;
    int tests_failed;
    string test_name;
    logic collecting;
    bitboard_t exp_table [`BOARD_SQUARES];
    bitboard_t act_table [`BOARD_SQUARES];
    bitboard_t ref_own;
    int exp_count;
    int act_count;

    move_generator move_generator_inst (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .valid_in(valid_in),
        .black_to_move(black_to_move),
        .white_pieces(white_pieces),
        .knights(knights),
        .bishops(bishops),
        .rooks(rooks),
        .queens(queens),
        .white_king(white_king),
        .black_king(black_king),
        .move(move),
        .move_valid(move_valid),
        .ready(ready)
    );

    initial begin
        clk_in = 1'b0;
        forever #(CLK_PERIOD / 2) clk_in = ~clk_in;
    end

    task automatic check_value(input string label, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s %s: expected %h, actual %h", test_name, label, expected, actual);
            errors++;
        end
    endtask

    // one step, or a full ray for sliders, stopping at the first occupied square
    function automatic bitboard_t ray_walk(int sq, int dr, int df, bitboard_t occ,
                                           bitboard_t own, bit slide);
        bitboard_t dsts;
        int r;
        int f;
        int to;
        bit go;

        dsts = '0;
        r = sq / 8 + dr;
        f = sq % 8 + df;
        go = 1'b1;
        while (go && r >= 0 && r < 8 && f >= 0 && f < 8) begin
            to = r * 8 + f;
            if (own[to]) begin
                go = 1'b0;
            end else begin
                dsts[to] = 1'b1;
                if (occ[to] || !slide) begin
                    go = 1'b0;
                end
            end
            r += dr;
            f += df;
        end
        return dsts;
    endfunction

    function automatic bitboard_t reference_dsts(int sq, bitboard_t occ, bitboard_t own,
                                                 bit king, bit knight, bit diag, bit ortho);
        bitboard_t d;

        d = '0;
        for (int dr = -1; dr <= 1; dr++) begin
            for (int df = -1; df <= 1; df++) begin
                if (dr != 0 || df != 0) begin
                    if (king) d |= ray_walk(sq, dr, df, occ, own, 1'b0);
                    if (diag && dr != 0 && df != 0) d |= ray_walk(sq, dr, df, occ, own, 1'b1);
                    if (ortho && (dr == 0 || df == 0)) d |= ray_walk(sq, dr, df, occ, own, 1'b1);
                end
            end
        end
        if (knight) begin
            for (int i = 0; i < 8; i++) begin
                d |= ray_walk(sq, KNIGHT_DR[i], KNIGHT_DF[i], occ, own, 1'b0);
            end
        end
        return d;
    endfunction

    // fills exp_table per source square and returns the move count
    function automatic int reference_moves(logic btm, bitboard_t wp, bitboard_t kn,
                                           bitboard_t bi, bitboard_t ro, bitboard_t qu,
                                           square_t wk, square_t bk);
        bitboard_t occ;
        bitboard_t white;
        square_t mk;
        int count;

        occ = wp | kn | bi | ro | qu | (bitboard_t'(1) << wk) | (bitboard_t'(1) << bk);
        white = wp | (bitboard_t'(1) << wk);
        ref_own = btm ? (occ & ~white) : (occ & white);
        mk = btm ? bk : wk;
        count = 0;
        for (int sq = 0; sq < `BOARD_SQUARES; sq++) begin
            exp_table[sq] = '0;
            if (ref_own[sq]) begin
                exp_table[sq] = reference_dsts(sq, occ, ref_own, sq == int'(mk), kn[sq],
                                               bi[sq] | qu[sq], ro[sq] | qu[sq]);
            end
            count += $countones(exp_table[sq]);
        end
        return count;
    endfunction

    function automatic int king_distance(square_t a, square_t b);
        rank_t ra;
        rank_t rb;
        file_t fa;
        file_t fb;
        int dr;
        int df;

        ra = a[5:3];
        rb = b[5:3];
        fa = a[2:0];
        fb = b[2:0];
        dr = (ra > rb) ? int'(ra - rb) : int'(rb - ra);
        df = (fa > fb) ? int'(fa - fb) : int'(fb - fa);
        return (dr > df) ? dr : df;
    endfunction

    // every move seen on the output goes into the actual table
    always @(negedge clk_in) begin
        if (move_valid === 1'b1) begin
            if (ready !== 1'b0) begin
                $display("move %0d to %0d came out while ready was high in %s",
                         move.src, move.dst, test_name);
                errors++;
            end else if (!collecting) begin
                $display("move %0d to %0d came out while no board was pending in %s",
                         move.src, move.dst, test_name);
                errors++;
            end else if (act_table[move.src][move.dst]) begin
                $display("move %0d to %0d was emitted twice in %s", move.src, move.dst, test_name);
                errors++;
            end else begin
                act_table[move.src][move.dst] = 1'b1;
                act_count++;
            end
        end
    end

    task automatic run_board(input logic btm, input bitboard_t wp, input bitboard_t kn,
                             input bitboard_t bi, input bitboard_t ro, input bitboard_t qu,
                             input square_t wk, input square_t bk);
        bitboard_t all_dsts;

        exp_count = reference_moves(btm, wp, kn, bi, ro, qu, wk, bk);
        for (int sq = 0; sq < `BOARD_SQUARES; sq++) begin
            act_table[sq] = '0;
        end
        act_count = 0;
        while (!ready) @(negedge clk_in);
        @(posedge clk_in);
        black_to_move <= btm;
        white_pieces <= wp;
        knights <= kn;
        bishops <= bi;
        rooks <= ro;
        queens <= qu;
        white_king <= wk;
        black_king <= bk;
        valid_in <= 1'b1;
        collecting = 1'b1;
        @(posedge clk_in);
        valid_in <= 1'b0;
        @(negedge clk_in);
        while (!ready) @(negedge clk_in);
        collecting = 1'b0;

        check_value("move count", exp_count, act_count);
        all_dsts = '0;
        for (int sq = 0; sq < `BOARD_SQUARES; sq++) begin
            check_value($sformatf("destinations of square %0d", sq), exp_table[sq], act_table[sq]);
            all_dsts |= act_table[sq];
        end
        check_value("own squares taken", '0, all_dsts & ref_own);
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errors = errors;
        tests_run++;
    endtask

    task automatic finish_test();
        if (errors == test_errors) begin
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: %0d errors", test_name, errors - test_errors);
            tests_failed++;
        end
    endtask

    task automatic random_boards();
        bitboard_t used;
        bitboard_t wp;
        bitboard_t kn;
        bitboard_t bi;
        bitboard_t ro;
        bitboard_t qu;
        square_t wk;
        square_t bk;
        square_t sq;
        logic [1:0] kind;
        logic [31:0] rnd;
        int n;

        for (int b = 0; b < RANDOM_BOARDS; b++) begin
            wk = square_t'($random(seed));
            bk = wk;
            while (king_distance(wk, bk) < 2) bk = square_t'($random(seed));
            used = (bitboard_t'(1) << wk) | (bitboard_t'(1) << bk);
            wp = '0;
            kn = '0;
            bi = '0;
            ro = '0;
            qu = '0;
            rnd = $random(seed);
            n = int'(rnd[3:0]) % 9;
            for (int p = 0; p < n; p++) begin
                sq = square_t'($random(seed));
                while (used[sq]) sq = square_t'($random(seed));
                used[sq] = 1'b1;
                rnd = $random(seed);
                kind = rnd[1:0];
                case (kind)
                    2'd0: kn[sq] = 1'b1;
                    2'd1: bi[sq] = 1'b1;
                    2'd2: ro[sq] = 1'b1;
                    default: qu[sq] = 1'b1;
                endcase
                wp[sq] = rnd[2];
            end
            rnd = $random(seed);
            run_board(rnd[0], wp, kn, bi, ro, qu, wk, bk);
        end
    endtask

    initial begin
        bitboard_t q_set;
        bitboard_t r_set;
        bitboard_t b_set;
        bitboard_t blockers;

        seed = 32'hc7e51b3d;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        collecting = 1'b0;
        test_name = "reset";
        rst_in = 1'b1;
        valid_in = 1'b0;
        black_to_move = 1'b0;
        white_pieces = '0;
        knights = '0;
        bishops = '0;
        rooks = '0;
        queens = '0;
        white_king = 6'd0;
        black_king = 6'd63;
        repeat (RESET_CYCLES) @(posedge clk_in);
        rst_in <= 1'b0;

        start_test("idle_after_reset");
        repeat (20) begin
            @(negedge clk_in);
            check_value("ready", 1, ready);
            check_value("move_valid", 0, move_valid);
        end
        finish_test();

        // corner, edge and centre
        start_test("lone_king");
        run_board(1'b0, '0, '0, '0, '0, '0, 6'd0, 6'd63);
        run_board(1'b0, '0, '0, '0, '0, '0, 6'd24, 6'd63);
        run_board(1'b0, '0, '0, '0, '0, '0, 6'd28, 6'd63);
        finish_test();

        // knights on a4 and h5, own rook b6 and bishop f6, enemy bishop c5 and rook g3
        start_test("knights");
        run_board(1'b0, 64'h0000_2280_0100_0000, 64'h0000_0080_0100_0000,
                  64'h0000_2004_0000_0000, 64'h0000_0200_0040_0000, '0, 6'd4, 6'd60);
        check_value("enemy bishop c5", 1, act_table[24][34]);
        check_value("own rook b6", 0, act_table[24][41]);
        check_value("wrap from a-file", '0, act_table[24] & 64'hc0c0c0c0c0c0c0c0);
        check_value("wrap from h-file", '0, act_table[39] & 64'h0303030303030303);
        finish_test();

        // rook d4 and bishop c1, each with one own and one enemy blocker
        start_test("sliders");
        run_board(1'b0, 64'h0000_0800_0810_0004, 64'h0000_0800_0010_0200,
                  64'h0000_0000_2000_0004, 64'h0000_0000_0800_0000, '0, 6'd7, 6'd63);
        check_value("rook own d6", 0, act_table[27][43]);
        check_value("rook past own d7", 0, act_table[27][51]);
        check_value("rook enemy f4", 1, act_table[27][29]);
        check_value("rook past enemy g4", 0, act_table[27][30]);
        check_value("bishop own e3", 0, act_table[2][20]);
        check_value("bishop enemy b2", 1, act_table[2][9]);
        check_value("bishop past enemy a3", 0, act_table[2][16]);
        finish_test();

        // same square and blockers for queen, rook and bishop
        start_test("queen_union");
        blockers = 64'h0000_2800_0200_0000;
        run_board(1'b0, 64'h0000_0800_0800_0000, blockers, '0, '0,
                  64'h0000_0000_0800_0000, 6'd7, 6'd63);
        q_set = act_table[27];
        run_board(1'b0, 64'h0000_0800_0800_0000, blockers, '0,
                  64'h0000_0000_0800_0000, '0, 6'd7, 6'd63);
        r_set = act_table[27];
        run_board(1'b0, 64'h0000_0800_0800_0000, blockers,
                  64'h0000_0000_0800_0000, '0, '0, 6'd7, 6'd63);
        b_set = act_table[27];
        check_value("queen equals rook and bishop", r_set | b_set, q_set);
        finish_test();

        start_test("black_to_move");
        run_board(1'b0, 64'h0000_2280_0100_0000, 64'h0000_0080_0100_0000,
                  64'h0000_2004_0000_0000, 64'h0000_0200_0040_0000, '0, 6'd4, 6'd60);
        run_board(1'b1, 64'h0000_2280_0100_0000, 64'h0000_0080_0100_0000,
                  64'h0000_2004_0000_0000, 64'h0000_0200_0040_0000, '0, 6'd4, 6'd60);
        check_value("white knight silent", '0, act_table[24]);
        finish_test();

        start_test("random_boards");
        random_boards();
        repeat (5) @(negedge clk_in);
        finish_test();

        $display("summary: %0d tests run, %0d with errors, %0d errors in total",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        repeat (RESET_CYCLES + 40 + (DIRECTED_BOARDS + RANDOM_BOARDS) * CYCLES_PER_BOARD) begin
            @(posedge clk_in);
        end
        $display("watchdog: the run exceeded its cycle budget, a board never finished");
        $display("Test failed");
        $finish;
    end

endmodule

//--- hw/move_generator.sv
`timescale 1ns/10ps
`include "movegen_params.svh"

module move_generator import board_pkg::*, move_pkg::*; (
    input logic clk_in,
    input logic rst_in,
    input logic valid_in,
    input logic black_to_move,
    input bitboard_t white_pieces,
    input bitboard_t knights,
    input bitboard_t bishops,
    input bitboard_t rooks,
    input bitboard_t queens,
    input square_t white_king,
    input square_t black_king,
    output move_t move,
    output logic move_valid,
    output logic ready
);

    logic accept;

    lane_if lanes [`NB_LANES] ();

    assign accept = valid_in & ready;

    board_decoder board_decoder_inst (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .accept(accept),
        .black_to_move(black_to_move),
        .white_pieces(white_pieces),
        .knights(knights),
        .bishops(bishops),
        .rooks(rooks),
        .queens(queens),
        .white_king(white_king),
        .black_king(black_king),
        .lanes(lanes)
    );

    for (genvar i = 0; i < `NB_LANES; i++) begin : g_lanes
        localparam lane_kind_t KIND = (i == `LANE_KING) ? KIND_KING
                                    : (i == `LANE_KNIGHT) ? KIND_KNIGHT
                                    : (i == `LANE_DIAG) ? KIND_DIAG : KIND_ORTHO;

        piece_lane #(
            .KIND(KIND)
        ) piece_lane_inst (
            .clk_in(clk_in),
            .rst_in(rst_in),
            .lane(lanes[i])
        );
    end

    move_arbiter move_arbiter_inst (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .valid_in(valid_in),
        .lanes(lanes),
        .move(move),
        .move_valid(move_valid),
        .ready(ready)
    );

endmodule

//--- hw/move_arbiter.sv
`timescale 1ns/10ps
`include "movegen_params.svh"

module move_arbiter import move_pkg::*; (
    input logic clk_in,
    input logic rst_in,
    input logic valid_in,
    lane_if.arbiter lanes [`NB_LANES],
    output move_t move,
    output logic move_valid,
    output logic ready
);

    logic [`NB_LANES-1:0] has_move;
    logic [`NB_LANES-1:0] busy;
    logic [`NB_LANES-1:0] load;
    logic [`NB_LANES-1:0] grant;
    move_t offer [`NB_LANES];
    move_t granted_move;

    for (genvar i = 0; i < `NB_LANES; i++) begin : g_lane
        assign has_move[i] = lanes[i].has_move;
        assign busy[i] = lanes[i].busy;
        assign load[i] = lanes[i].load;
        assign offer[i] = lanes[i].offer;
        assign lanes[i].grant = grant[i];
    end

    // lowest index wins
    assign grant = has_move & (~has_move + 1'b1);

    always_comb begin
        granted_move = '0;
        for (int i = 0; i < `NB_LANES; i++) begin
            if (grant[i]) begin
                granted_move = offer[i];
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (|grant) begin
            move <= granted_move;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            move_valid <= 1'b0;
            ready <= 1'b1;
        end else begin
            move_valid <= |grant;
            if (valid_in && ready) begin
                ready <= 1'b0;
            end else begin
                ready <= ~(|busy) & ~(|load);
            end
        end
    end

    // no lane may still offer a move once the board is done
    a_quiet_when_ready: assert property (@(posedge clk_in) disable iff (rst_in)
        ready |-> !(|grant) && !move_valid);

    a_reset_quiet: assert property (@(posedge clk_in)
        rst_in |=> !move_valid && ready && !(|busy));

    a_valid_when_ready: assert property (@(posedge clk_in) disable iff (rst_in)
        valid_in |-> ready);

endmodule

//--- hw/piece_lane.sv
`timescale 1ns/10ps

module piece_lane import board_pkg::*, move_pkg::*; #(
    parameter lane_kind_t KIND = KIND_KING
) (
    input logic clk_in,
    input logic rst_in,
    lane_if.lane lane
);

    lane_state_t state;
    // current piece stays in pieces until its last move is taken
    bitboard_t pieces;
    bitboard_t dsts;

    square_t src;
    square_t dst;
    bitboard_t attacks;
    bitboard_t piece_dsts;
    bitboard_t pieces_rest;
    bitboard_t dsts_rest;
    logic piece_done;

    assign src = lowest_square(pieces);
    assign dst = lowest_square(dsts);
    assign pieces_rest = pieces & (pieces - 1'b1);
    assign dsts_rest = dsts & (dsts - 1'b1);

    attack_unit #(
        .KIND(KIND)
    ) attack_unit_inst (
        .square(src),
        .occupied(lane.occupied),
        .attacks(attacks)
    );

    assign piece_dsts = (pieces != '0) ? (attacks & ~lane.own) : '0;

    // last destination of the piece taken this cycle
    assign piece_done = (state == ST_EMIT) && lane.grant && (dsts_rest == '0);

    assign lane.offer = {src, dst};
    assign lane.has_move = (state == ST_EMIT) && (dsts != '0);
    assign lane.busy = (state != ST_IDLE);

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: if (lane.load) state <= ST_LOAD;
                ST_LOAD: begin
                    if (piece_dsts != '0) begin
                        state <= ST_EMIT;
                    end else if (pieces_rest == '0) begin
                        state <= ST_IDLE;
                    end
                end
                ST_EMIT: if (piece_done) state <= (pieces_rest != '0) ? ST_LOAD : ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (state == ST_IDLE && lane.load) begin
            pieces <= lane.pieces;
        end else if ((state == ST_LOAD && piece_dsts == '0) || piece_done) begin
            pieces <= pieces_rest;
        end

        if (state == ST_LOAD) begin
            dsts <= piece_dsts;
        end else if (state == ST_EMIT && lane.grant) begin
            dsts <= dsts_rest;
        end
    end

    a_offer_from_emit: assert property (@(posedge clk_in) disable iff (rst_in)
        lane.has_move |-> (state == ST_EMIT) && !lane.own[dst]);

    // an offer not taken stays the same on the next cycle
    a_offer_held: assert property (@(posedge clk_in) disable iff (rst_in)
        lane.has_move && !lane.grant |=> lane.has_move && $stable(lane.offer));

endmodule

//--- hw/attack_unit.sv
`timescale 1ns/10ps
`include "movegen_params.svh"

module attack_unit import board_pkg::*, move_pkg::*; #(
    parameter lane_kind_t KIND = KIND_KING
) (
    input square_t square,
    input bitboard_t occupied,
    output bitboard_t attacks
);

    localparam bitboard_t FILE_A = 64'h0101010101010101;
    localparam bitboard_t FILE_H = 64'h8080808080808080;
    localparam bitboard_t FILE_AB = 64'h0303030303030303;
    localparam bitboard_t FILE_GH = 64'hc0c0c0c0c0c0c0c0;
    // a1-h8 and h1-a8 diagonals
    localparam bitboard_t MAIN_DIAG = 64'h8040201008040201;
    localparam bitboard_t ANTI_DIAG = 64'h0102040810204080;

    function automatic bitboard_t reverse_bits(bitboard_t bb);
        bitboard_t rev;

        for (int i = 0; i < `BOARD_SQUARES; i++) begin
            rev[i] = bb[`BOARD_SQUARES-1-i];
        end
        return rev;
    endfunction

    // o - 2r gives the upward ray, the same on the reversed board gives the downward one
    function automatic bitboard_t line_attacks(bitboard_t occ, bitboard_t line, bitboard_t src_bb);
        bitboard_t o;
        bitboard_t fwd;
        bitboard_t bwd;

        o = occ & line;
        fwd = o - (src_bb << 1);
        bwd = reverse_bits(o) - (reverse_bits(src_bb) << 1);
        return (fwd ^ reverse_bits(bwd)) & line;
    endfunction

    always_comb begin
        rank_t sq_rank;
        file_t sq_file;
        logic [3:0] rank_file_sum;
        bitboard_t src_bb;
        bitboard_t occ_x;
        bitboard_t east;
        bitboard_t west;
        bitboard_t row;
        bitboard_t king_steps;
        bitboard_t knight_steps;
        bitboard_t rank_line;
        bitboard_t file_line;
        bitboard_t diag_line;
        bitboard_t anti_line;

        sq_rank = square[5:3];
        sq_file = square[2:0];
        src_bb = bitboard_t'(1) << square;
        occ_x = occupied & ~src_bb;

        // file guards stop steps from wrapping to the other board edge
        east = (src_bb << 1) & ~FILE_A;
        west = (src_bb >> 1) & ~FILE_H;
        row = src_bb | east | west;
        king_steps = (row << 8) | (row >> 8) | east | west;

        knight_steps = ((src_bb << 17) & ~FILE_A) | ((src_bb << 15) & ~FILE_H)
                     | ((src_bb << 10) & ~FILE_AB) | ((src_bb << 6) & ~FILE_GH)
                     | ((src_bb >> 17) & ~FILE_H) | ((src_bb >> 15) & ~FILE_A)
                     | ((src_bb >> 10) & ~FILE_GH) | ((src_bb >> 6) & ~FILE_AB);

        rank_line = (bitboard_t'(8'hff) << (sq_rank * `BOARD_FILES)) & ~src_bb;
        file_line = (FILE_A << sq_file) & ~src_bb;

        if (sq_file >= sq_rank) begin
            diag_line = MAIN_DIAG >> ((sq_file - sq_rank) * `BOARD_FILES);
        end else begin
            diag_line = MAIN_DIAG << ((sq_rank - sq_file) * `BOARD_FILES);
        end
        diag_line = diag_line & ~src_bb;

        rank_file_sum = sq_rank + sq_file;
        if (rank_file_sum >= 4'd7) begin
            anti_line = ANTI_DIAG << ((rank_file_sum - 4'd7) * `BOARD_FILES);
        end else begin
            anti_line = ANTI_DIAG >> ((4'd7 - rank_file_sum) * `BOARD_FILES);
        end
        anti_line = anti_line & ~src_bb;

        case (KIND)
            KIND_KING: attacks = king_steps;
            KIND_KNIGHT: attacks = knight_steps;
            KIND_DIAG: attacks = line_attacks(occ_x, diag_line, src_bb)
                               | line_attacks(occ_x, anti_line, src_bb);
            default: attacks = line_attacks(occ_x, rank_line, src_bb)
                             | line_attacks(occ_x, file_line, src_bb);
        endcase
    end

endmodule

//--- hw/board_decoder.sv
`timescale 1ns/10ps
`include "movegen_params.svh"

module board_decoder import board_pkg::*; (
    input logic clk_in,
    input logic rst_in,
    input logic accept,
    input logic black_to_move,
    input bitboard_t white_pieces,
    input bitboard_t knights,
    input bitboard_t bishops,
    input bitboard_t rooks,
    input bitboard_t queens,
    input square_t white_king,
    input square_t black_king,
    lane_if.decoder lanes [`NB_LANES]
);

    bitboard_t white_bb;
    bitboard_t mover_king_bb;
    bitboard_t occupied_d;
    bitboard_t own_d;
    bitboard_t lane_sets_d [`NB_LANES];

    bitboard_t occupied_q;
    bitboard_t own_q;
    bitboard_t lane_sets_q [`NB_LANES];
    logic load_q;

    always_comb begin
        white_bb = white_pieces | (bitboard_t'(1) << white_king);
        occupied_d = white_pieces | knights | bishops | rooks | queens
                   | (bitboard_t'(1) << white_king) | (bitboard_t'(1) << black_king);
        own_d = black_to_move ? (occupied_d & ~white_bb) : (occupied_d & white_bb);
        mover_king_bb = bitboard_t'(1) << (black_to_move ? black_king : white_king);

        // queens feed both slider lanes
        lane_sets_d[`LANE_KING] = mover_king_bb;
        lane_sets_d[`LANE_KNIGHT] = knights & own_d;
        lane_sets_d[`LANE_DIAG] = (bishops | queens) & own_d;
        lane_sets_d[`LANE_ORTHO] = (rooks | queens) & own_d;
    end

    always_ff @(posedge clk_in) begin
        if (accept) begin
            occupied_q <= occupied_d;
            own_q <= own_d;
            lane_sets_q <= lane_sets_d;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            load_q <= 1'b0;
        end else begin
            load_q <= accept;
        end
    end

    for (genvar i = 0; i < `NB_LANES; i++) begin : g_lane
        assign lanes[i].load = load_q;
        assign lanes[i].pieces = lane_sets_q[i];
        assign lanes[i].occupied = occupied_q;
        assign lanes[i].own = own_q;
    end

endmodule

//--- hw/lane_if.sv
`timescale 1ns/10ps

interface lane_if import board_pkg::*, move_pkg::*; ();

    // from the decoder, held until the next board
    logic load;
    bitboard_t pieces;
    bitboard_t occupied;
    bitboard_t own;

    // lane offer, held until granted
    move_t offer;
    logic has_move;
    logic busy;

    logic grant;

    modport decoder (output load, output pieces, output occupied, output own);

    modport lane (
        input load, input pieces, input occupied, input own, input grant,
        output offer, output has_move, output busy
    );

    modport arbiter (input load, input offer, input has_move, input busy, output grant);

endinterface

//--- hw/move_pkg.sv
package move_pkg;

    import board_pkg::*;

    typedef struct packed {
        square_t src;
        square_t dst;
    } move_t;

    // move source served by a lane
    typedef enum logic [1:0] {
        KIND_KING,
        KIND_KNIGHT,
        KIND_DIAG,
        KIND_ORTHO
    } lane_kind_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOAD,
        ST_EMIT
    } lane_state_t;

endpackage

//--- hw/board_pkg.sv
`include "movegen_params.svh"

package board_pkg;

    // one bit per square, index is rank * 8 + file
    typedef logic [`BOARD_SQUARES-1:0] bitboard_t;
    typedef logic [5:0] square_t;
    typedef logic [2:0] rank_t;
    typedef logic [2:0] file_t;

    // index of the lowest set bit, zero for an empty set
    function automatic square_t lowest_square(bitboard_t bb);
        bitboard_t onehot;
        square_t idx;

        onehot = bb & (~bb + 1'b1);
        idx = '0;
        for (int i = 0; i < `BOARD_SQUARES; i++) begin
            if (onehot[i]) begin
                idx = idx | square_t'(i);
            end
        end
        return idx;
    endfunction

endpackage

//--- include/movegen_params.svh
`ifndef MOVEGEN_PARAMS_SVH
`define MOVEGEN_PARAMS_SVH

// board geometry
`define BOARD_SQUARES 64
`define BOARD_FILES 8

// number of piece lanes between decoder and arbiter
`define NB_LANES 4

// lane numbering, lower index wins arbitration
`define LANE_KING 0
`define LANE_KNIGHT 1
`define LANE_DIAG 2
`define LANE_ORTHO 3

`endif
